/* tb.f */
cpu_pkg.sv
decoder.sv
register_file.sv
alu.sv
pc_reg.sv
top.sv
tb_clock.sv
tb_top.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_top
FILELIST = tb.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  import cpu_pkg::*;

  // architectural state as the model sees it
  typedef struct packed {
    logic [31:0][63:0] regs;
    logic [63:0]       pc;
    logic              halted;
  } model_t;

  logic            clk;
  logic            rst_n;
  logic            inst_valid;
  inst_u           inst;
  logic            inst_ready;
  logic [xlen-1:0] current_pc;
  logic            retire_valid;
  retire_t         retire;

  model_t  model;
  retire_t exp_q [$];
  int      seed = 78;
  int      errors = 0;
  int      pass_tests = 0;
  int      fail_tests = 0;

  tb_clock u_clock (.clk(clk));

  top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_ready   (inst_ready),
    .current_pc   (current_pc),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  // instruction encoders built from the raw formats
  function automatic logic [31:0] addi_word(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h13};
  endfunction

  function automatic logic [31:0] add_word(input int rd, input int rs1, input int rs2);
    return {7'h00, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] upper_word(input int rd, input int imm20,
                                             input logic [6:0] opc);
    return {imm20[19:0], rd[4:0], opc};
  endfunction

  // predicts the retire record and advances the model state
  function automatic retire_t predict(input logic [31:0] w, inout model_t st);
    retire_t     r;
    logic [6:0]  opc;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [63:0] immi;
    logic [63:0] immu;
    opc  = w[6:0];
    rd   = w[11:7];
    rs1  = w[19:15];
    rs2  = w[24:20];
    immi = {{52{w[31]}}, w[31:20]};
    immu = {{32{w[31]}}, w[31:12], 12'h000};
    r = '0;
    r.pc = st.pc;
    r.illegal = 1'b1;
    if (opc == 7'h13 && w[14:12] == 3'b000) begin
      r.wen = 1'b1;
      r.wdata = st.regs[rs1] + immi;
    end else if (opc == 7'h33 && w[14:12] == 3'b000 && w[31:25] == 7'h00) begin
      r.wen = 1'b1;
      r.wdata = st.regs[rs1] + st.regs[rs2];
    end else if (opc == 7'h37) begin
      r.wen = 1'b1;
      r.wdata = immu;
    end else if (opc == 7'h17) begin
      r.wen = 1'b1;
      r.wdata = st.pc + immu;
    end else if (w == 32'h0010_0073) begin
      r.halt = 1'b1;
      r.illegal = 1'b0;
    end
    if (r.wen) begin
      r.illegal = 1'b0;
      r.rd = rd;
      // x0 keeps zero
      if (rd != 5'd0) begin
        st.regs[rd] = r.wdata;
      end
    end
    st.pc = st.pc + 64'd4;
    if (r.halt) begin
      st.halted = 1'b1;
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    errors++;
  endtask

  task automatic abort_run(input string msg);
    $display("error at %0t: %s", $time, msg);
    $display("TEST FAILED");
    $finish;
  endtask

  // drive one word and hold it until the handshake
  task automatic send(input logic [31:0] w);
    int      waited;
    retire_t r;
    waited = 0;
    inst_valid = 1'b1;
    inst = w;
    while (!inst_ready) begin
      if (waited == 50) begin
        abort_run("inst_ready stayed low while sending an instruction");
      end
      @(posedge clk);
      #1;
      waited++;
    end
    if (current_pc !== model.pc) begin
      report_mismatch("current_pc", model.pc, current_pc);
    end
    @(posedge clk);
    #1;
    // transfer happened at that edge
    r = predict(w, model);
    exp_q.push_back(r);
    inst_valid = 1'b0;
  endtask

  // idle cycles where the pc must not move
  task automatic idle(input int n);
    inst_valid = 1'b0;
    repeat (n) begin
      if (current_pc !== model.pc) begin
        report_mismatch("current_pc", model.pc, current_pc);
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == 20) begin
        abort_run("expected retire records never drained");
      end
      @(posedge clk);
      #1;
      waited++;
    end
    if (errors == errs_before) begin
      pass_tests++;
      $display("test %s: ok", name);
    end else begin
      fail_tests++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  // compare every retire record against the head of the queue
  initial begin : compare
    retire_t exp;
    int      waited;
    waited = 0;
    forever begin
      @(posedge clk);
      #2;
      if (retire_valid) begin
        waited = 0;
        if (exp_q.size() == 0) begin
          $display("error at %0t: retire record with no instruction pending", $time);
          errors++;
        end else begin
          exp = exp_q.pop_front();
          if (retire.pc !== exp.pc) report_mismatch("retire.pc", exp.pc, retire.pc);
          if (retire.rd !== exp.rd) report_mismatch("retire.rd", 64'(exp.rd), 64'(retire.rd));
          if (retire.wdata !== exp.wdata) begin
            report_mismatch("retire.wdata", exp.wdata, retire.wdata);
          end
          if (retire.wen !== exp.wen) begin
            report_mismatch("retire.wen", 64'(exp.wen), 64'(retire.wen));
          end
          if (retire.illegal !== exp.illegal) begin
            report_mismatch("retire.illegal", 64'(exp.illegal), 64'(retire.illegal));
          end
          if (retire.halt !== exp.halt) begin
            report_mismatch("retire.halt", 64'(exp.halt), 64'(retire.halt));
          end
        end
      end else if (exp_q.size() != 0) begin
        // pending record not retired yet
        waited++;
        if (waited > 10) begin
          abort_run("no retire_valid for a pending instruction");
        end
      end
    end
  end

  initial begin : stimulus
    int base;
    rst_n = 1'b0;
    inst_valid = 1'b0;
    inst = '0;
    model = '0;
    model.pc = reset_pc;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // addi chain with both signs and imm limits
    base = errors;
    send(addi_word(1, 0, 5));
    send(addi_word(2, 1, -3));
    send(addi_word(3, 2, 2047));
    send(addi_word(4, 3, -2048));
    send(addi_word(1, 1, -1));
    finish_test("immediate arithmetic", base);

    // back-to-back adds with x0 as target and source
    base = errors;
    send(add_word(5, 1, 2));
    send(add_word(6, 5, 5));
    send(add_word(0, 5, 6));
    send(add_word(7, 0, 5));
    send(addi_word(0, 0, 100));
    send(add_word(8, 0, 0));
    finish_test("register add and x0", base);

    // lui with both signs of imm20 and auipc off the pc
    base = errors;
    send(upper_word(9, 'h12345, 7'h37));
    send(upper_word(10, 'hfffff, 7'h37));
    send(upper_word(11, 'h00001, 7'h17));
    send(upper_word(12, 'h80000, 7'h17));
    send(add_word(13, 9, 10));
    finish_test("upper immediates", base);

    // sub, xori, ld, ecall and sll, then read x1 back
    base = errors;
    send({7'h20, 5'd3, 5'd2, 3'b000, 5'd1, 7'h33});
    send({12'h0ff, 5'd1, 3'b100, 5'd1, 7'h13});
    send(32'h0000_b083);
    send(32'h0000_0073);
    send({7'h00, 5'd2, 5'd1, 3'b001, 5'd1, 7'h33});
    send(add_word(14, 1, 0));
    finish_test("illegal encodings", base);

    // random idle gaps between addi steps
    base = errors;
    for (int i = 0; i < 12; i++) begin
      idle($unsigned($random(seed)) % 4);
      send(addi_word(15, 15, i - 6));
    end
    finish_test("input gaps", base);

    // ebreak then valid held high against a halted core
    base = errors;
    send(32'h0010_0073);
    finish_test("halt retire", base);
    base = errors;
    inst_valid = 1'b1;
    inst = addi_word(1, 1, 1);
    repeat (20) begin
      if (inst_ready !== 1'b0) report_mismatch("inst_ready", 64'd0, 64'(inst_ready));
      @(posedge clk);
      #1;
    end
    inst_valid = 1'b0;
    finish_test("halt stall", base);

    $display("tests passed %0d, failed %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // 4 ns period, starts low
  initial begin
    clk = 1'b0;
  end

  always begin
    #2;
    clk = ~clk;
  end

endmodule

`default_nettype wire

/* top.sv */
`timescale 1ns/1ps
`default_nettype none

module top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     inst_valid,
  input  cpu_pkg::inst_u           inst,
  output logic                     inst_ready,
  output logic [cpu_pkg::xlen-1:0] current_pc,
  output logic                     retire_valid,
  output cpu_pkg::retire_t         retire
);

  import cpu_pkg::*;

  // decode outputs
  logic [reg_id_w-1:0] rd;
  logic [reg_id_w-1:0] rs1;
  logic [reg_id_w-1:0] rs2;
  logic [xlen-1:0]     imm;
  logic                use_imm;
  logic                use_pc;
  logic                zero_a;
  logic                writes_rd;
  logic                is_ebreak;
  logic                illegal;
  alu_op_e             alu_op;

  // execute path
  logic [xlen-1:0] rdata_1;
  logic [xlen-1:0] rdata_2;
  logic [xlen-1:0] operand_a;
  logic [xlen-1:0] operand_b;
  logic [xlen-1:0] result;
  logic            halted;
  logic            accept;
  logic            rf_wen;

  // only halt stalls the input handshake
  assign inst_ready = !halted;
  assign accept     = inst_valid && inst_ready;
  // nothing is written unless the instruction is taken
  assign rf_wen     = accept && writes_rd;

  decoder u_decoder (
    .inst      (inst),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .imm       (imm),
    .use_imm   (use_imm),
    .use_pc    (use_pc),
    .zero_a    (zero_a),
    .writes_rd (writes_rd),
    .is_ebreak (is_ebreak),
    .illegal   (illegal),
    .alu_op    (alu_op)
  );

  register_file u_register_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .wen     (rf_wen),
    .rd      (rd),
    .rs1     (rs1),
    .rs2     (rs2),
    .wdata   (result),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  // operand a is pc for auipc, zero for lui and rs1 otherwise
  assign operand_a = use_pc ? current_pc : (zero_a ? '0 : rdata_1);
  // operand b is imm or rs2
  assign operand_b = use_imm ? imm : rdata_2;

  alu u_alu (
    .operand_a (operand_a),
    .operand_b (operand_b),
    .alu_op    (alu_op),
    .result    (result)
  );

  pc_reg u_pc_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .accept     (accept),
    .is_ebreak  (is_ebreak),
    .current_pc (current_pc),
    .next_pc    (),
    .halted     (halted)
  );

  // one retire strobe per accepted instruction
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= accept;
    end
  end

  // retire payload only loads on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      retire.pc      <= current_pc;
      retire.rd      <= writes_rd ? rd : '0;
      retire.wdata   <= writes_rd ? result : '0;
      retire.wen     <= writes_rd;
      retire.illegal <= illegal;
      retire.halt    <= is_ebreak;
    end
  end

  // a retire record needs an accepted instruction one edge earlier
  a_retire_needs_accept: assert property (
    @(posedge clk) disable iff (!rst_n)
      $rose(retire_valid) |-> $past(accept)
  ) else $error("top: retire_valid rose without an accepted instruction");

endmodule

`default_nettype wire

/* pc_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_reg (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     accept,
  input  logic                     is_ebreak,
  output logic [cpu_pkg::xlen-1:0] current_pc,
  output logic [cpu_pkg::xlen-1:0] next_pc,
  output logic                     halted
);

  import cpu_pkg::*;

  // sequential step, no branches in this core
  assign next_pc = current_pc + xlen'(4);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      current_pc <= reset_pc;
      halted     <= 1'b0;
    end else if (accept) begin
      // illegal and ebreak still step the pc
      current_pc <= next_pc;
      // sticky until reset
      if (is_ebreak) begin
        halted <= 1'b1;
      end
    end
  end

  // idle cycles leave the pc alone
  a_pc_stable_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
      !accept |=> $stable(current_pc)
  ) else $error("pc_reg: pc moved without an accepted instruction");

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [cpu_pkg::xlen-1:0] operand_a,
  input  logic [cpu_pkg::xlen-1:0] operand_b,
  input  cpu_pkg::alu_op_e         alu_op,
  output logic [cpu_pkg::xlen-1:0] result
);

  import cpu_pkg::*;

  always_comb begin
    // only two ops are decoded, anything else is a decoder bug
    assert (alu_op inside {alu_add, alu_pass_b})
      else $error("alu: unknown op code %0d", alu_op);

    case (alu_op)
      alu_add: begin
        // addi, add, auipc
        result = operand_a + operand_b;
      end
      alu_pass_b: begin
        // lui, imm already shifted
        result = operand_b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         wen,
  input  logic [cpu_pkg::reg_id_w-1:0] rd,
  input  logic [cpu_pkg::reg_id_w-1:0] rs1,
  input  logic [cpu_pkg::reg_id_w-1:0] rs2,
  input  logic [cpu_pkg::xlen-1:0]     wdata,
  output logic [cpu_pkg::xlen-1:0]     rdata_1,
  output logic [cpu_pkg::xlen-1:0]     rdata_2
);

  import cpu_pkg::*;

  // x1..x31, x0 has no storage
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      // writes to x0 are dropped here
      regs[rd] <= wdata;
    end
  end

  // combinational reads, index 0 forced to zero
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

  // a write aimed at x0 must not show up on either read port
  property p_x0_stays_zero;
    @(posedge clk) disable iff (!rst_n)
      (wen && rd == '0) |=> ((rs1 != '0 || rdata_1 == '0) &&
                             (rs2 != '0 || rdata_2 == '0));
  endproperty
  a_x0_stays_zero: assert property (p_x0_stays_zero)
    else $error("register_file: x0 read nonzero after write to x0");

endmodule

`default_nettype wire

/* decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder (
  input  cpu_pkg::inst_u                   inst,
  output logic [cpu_pkg::reg_id_w-1:0]     rd,
  output logic [cpu_pkg::reg_id_w-1:0]     rs1,
  output logic [cpu_pkg::reg_id_w-1:0]     rs2,
  output logic [cpu_pkg::xlen-1:0]         imm,
  output logic                             use_imm,
  output logic                             use_pc,
  output logic                             zero_a,
  output logic                             writes_rd,
  output logic                             is_ebreak,
  output logic                             illegal,
  output cpu_pkg::alu_op_e                 alu_op
);

  import cpu_pkg::*;

  logic [6:0] opcode;

  // opcode and register ids sit at the same bits in every view
  assign opcode = inst.r_fmt.opcode;
  assign rd     = inst.r_fmt.rd;
  assign rs1    = inst.r_fmt.rs1;
  assign rs2    = inst.r_fmt.rs2;

  always_comb begin
    // safe defaults: no write, flagged illegal
    imm       = '0;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    zero_a    = 1'b0;
    writes_rd = 1'b0;
    is_ebreak = 1'b0;
    illegal   = 1'b1;
    alu_op    = alu_add;

    case (opcode)
      op_imm: begin
        // only addi, funct3 000
        if (inst.i_fmt.funct3 == 3'b000) begin
          imm       = {{(xlen-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
          use_imm   = 1'b1;
          writes_rd = 1'b1;
          illegal   = 1'b0;
        end
      end
      op_reg: begin
        // only add, sub and friends stay illegal
        if (inst.r_fmt.funct3 == 3'b000 && inst.r_fmt.funct7 == 7'b0000000) begin
          writes_rd = 1'b1;
          illegal   = 1'b0;
        end
      end
      op_lui: begin
        // upper imm, shifted up and sign extended to xlen
        imm       = {{(xlen-32){inst.u_fmt.imm20[19]}}, inst.u_fmt.imm20, 12'b0};
        use_imm   = 1'b1;
        zero_a    = 1'b1;
        alu_op    = alu_pass_b;
        writes_rd = 1'b1;
        illegal   = 1'b0;
      end
      op_auipc: begin
        // pc plus upper imm
        imm       = {{(xlen-32){inst.u_fmt.imm20[19]}}, inst.u_fmt.imm20, 12'b0};
        use_imm   = 1'b1;
        use_pc    = 1'b1;
        writes_rd = 1'b1;
        illegal   = 1'b0;
      end
      op_system: begin
        // exact ebreak only, every other field zero
        if (inst.i_fmt.imm12 == 12'h001 && inst.i_fmt.rs1 == '0 &&
            inst.i_fmt.funct3 == 3'b000 && inst.i_fmt.rd == '0) begin
          is_ebreak = 1'b1;
          illegal   = 1'b0;
        end
      end
      default: begin
        // unsupported major opcode, defaults stand
        illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // data path and register widths
  localparam int xlen     = 64;
  localparam int reg_id_w = 5;
  localparam int inst_w   = 32;

  // first fetch address out of reset
  localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;

  // major opcodes handled by this core
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_system = 7'b1110011;

  // register-register layout
  typedef struct packed {
    logic [6:0]          funct7;
    logic [reg_id_w-1:0] rs2;
    logic [reg_id_w-1:0] rs1;
    logic [2:0]          funct3;
    logic [reg_id_w-1:0] rd;
    logic [6:0]          opcode;
  } r_fmt_t;

  // 12-bit immediate layout
  typedef struct packed {
    logic [11:0]         imm12;
    logic [reg_id_w-1:0] rs1;
    logic [2:0]          funct3;
    logic [reg_id_w-1:0] rd;
    logic [6:0]          opcode;
  } i_fmt_t;

  // upper immediate layout
  typedef struct packed {
    logic [19:0]         imm20;
    logic [reg_id_w-1:0] rd;
    logic [6:0]          opcode;
  } u_fmt_t;

  // one instruction word, three ways to read it
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    u_fmt_t u_fmt;
  } inst_u;

  // add covers addi/add/auipc, pass_b covers lui
  typedef enum logic [1:0] {
    alu_add    = 2'd0,
    alu_pass_b = 2'd1
  } alu_op_e;

  // one retired instruction as seen on the trace port
  typedef struct packed {
    logic [xlen-1:0]     pc;
    logic [reg_id_w-1:0] rd;
    logic [xlen-1:0]     wdata;
    logic                wen;
    logic                illegal;
    logic                halt;
  } retire_t;

endpackage

`default_nettype wire
